/* design/fogBlend.sv */
`timescale 1ns/1ps

module fogBlend
(
    input  logic               aclk,
    input  logic               arstN,
    input  logic [15:0]        intensity,
    input  fragmentPkg::pixelT color,
    input  fragmentPkg::pixelT fogColor,
    output fragmentPkg::pixelT blended
);

    // Index 3 red down to 1 blue
    logic [3:0][7:0] colCh;
    logic [3:0][7:0] fogCh;

    logic [3:1][23:0] colProd;
    logic [3:1][23:0] fogProd;
    logic [7:0]       alphaQ;

    logic [3:0][7:0] mixed;

    assign colCh = color;
    assign fogCh = fogColor;

    // Stage 1, weight colour by intensity and fog by its complement
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            colProd <= '0;
            fogProd <= '0;
            alphaQ  <= '0;
        end
        else
        begin
            for (int i = 1; i < 4; i++)
            begin
                colProd[i] <= colCh[i] * intensity;
                fogProd[i] <= fogCh[i] * (16'hffff - intensity);
            end
            alphaQ <= colCh[0];
        end
    end

    // Stage 2, sum stays below 2^24 since weights add to 65535
    always_comb
    begin
        logic [23:0] sum;
        for (int i = 1; i < 4; i++)
        begin
            sum      = colProd[i] + fogProd[i];
            mixed[i] = sum[23:16];
        end
        // Alpha untouched by fog
        mixed[0] = alphaQ;
    end

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
            blended <= '0;
        else
            blended <= mixed;
    end

endmodule

/* design/fogInterpolator.sv */
`timescale 1ns/1ps
`include "fragment_defs.svh"

module fogInterpolator
(
    input  logic                  aclk,
    input  logic                  arstN,
    input  logic [15:0]           depth,
    input  logic                  fogValid,
    output logic                  fogReady,
    input  logic                  fogLast,
    input  fragmentPkg::fogEntryT fogData,
    output logic [15:0]           intensity
);

    localparam int idxBits  = $clog2(`FRAG_FOG_ENTRIES);
    localparam int fracBits = 16 - idxBits;
    localparam int prodBits = 16 + fracBits + 1;

    fragmentPkg::fogEntryT fogTable [`FRAG_FOG_ENTRIES];
    logic [idxBits-1:0] wrIdx;

    fragmentPkg::fogEntryT entryQ;
    logic [fracBits-1:0]   fracQ;
    logic signed [prodBits-1:0] product;
    logic signed [16:0]    prodQ;
    logic [15:0]           baseQ;
    logic signed [17:0]    sum;

    //////////////////////////////////////////////////////////////////////
    // Table load
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
            fogReady <= 1'b0;
        else
            fogReady <= 1'b1;
    end

    // Entries in order, last goes back to entry 0
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
            wrIdx <= '0;
        else if (fogValid && fogReady)
            wrIdx <= fogLast ? '0 : wrIdx + 1'b1;
    end

    always_ff @(posedge aclk)
    begin
        if (fogValid && fogReady)
            fogTable[wrIdx] <= fogData;
    end

    //////////////////////////////////////////////////////////////////////
    // Interpolation
    //////////////////////////////////////////////////////////////////////

    // Signed slope times unsigned fraction
    assign product = entryQ.slope * $signed({1'b0, fracQ});

    // Base plus scaled product, may leave 0..65535
    assign sum = $signed({2'b00, baseQ}) + $signed({prodQ[16], prodQ});

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            entryQ    <= '0;
            fracQ     <= '0;
            prodQ     <= '0;
            baseQ     <= '0;
            intensity <= '0;
        end
        else
        begin
            // Stage 1, segment from the top depth bits
            entryQ <= fogTable[depth[15 -: idxBits]];
            fracQ  <= depth[fracBits-1:0];
            // Stage 2, arithmetic shift back to 16-bit scale
            prodQ  <= product[prodBits-1:fracBits];
            baseQ  <= entryQ.base;
            // Stage 3, saturate
            if (sum[17])
                intensity <= 16'h0000;
            else if (sum[16])
                intensity <= 16'hffff;
            else
                intensity <= sum[15:0];
        end
    end

endmodule

/* design/fragmentPipeline.sv */
`timescale 1ns/1ps
`include "fragment_defs.svh"

module fragmentPipeline
(
    input  logic                  aclk,
    input  logic                  arstN,
    input  fragmentPkg::confT     conf,
    input  logic                  inValid,
    input  fragmentPkg::fragmentT inFrag,
    input  logic                  texValid,
    output logic                  texReady,
    input  logic                  texLast,
    input  fragmentPkg::pixelT    texData,
    input  logic                  fogValid,
    output logic                  fogReady,
    input  logic                  fogLast,
    input  fragmentPkg::fogEntryT fogData,
    output logic                  outValid,
    output fragmentPkg::pixelT    outColor
);

    // Extra cycles to bring fog intensity to the blend input
    localparam int fogAlign = `FRAG_LAT_SAMPLE + `FRAG_LAT_TEXENV - `FRAG_LAT_FOGLUT;

    fragmentPkg::pixelT texel;
    fragmentPkg::pixelT primaryAligned;
    fragmentPkg::pixelT envOut;
    logic [15:0] fogIntensity;
    logic [15:0] fogIntensitySel;
    logic [15:0] intensityAligned;

    //////////////////////////////////////////////////////////////////////
    // Texel fetch and fog lookup, both start at the input
    //////////////////////////////////////////////////////////////////////

    textureSampler uSampler (
        .aclk     (aclk),
        .arstN    (arstN),
        .s        (inFrag.s),
        .t        (inFrag.t),
        .clampS   (conf.clampS),
        .clampT   (conf.clampT),
        .texValid (texValid),
        .texReady (texReady),
        .texLast  (texLast),
        .texData  (texData),
        .texel    (texel)
    );

    fogInterpolator uFog (
        .aclk      (aclk),
        .arstN     (arstN),
        .depth     (inFrag.depth),
        .fogValid  (fogValid),
        .fogReady  (fogReady),
        .fogLast   (fogLast),
        .fogData   (fogData),
        .intensity (fogIntensity)
    );

    // Full intensity selects the colour side only
    assign fogIntensitySel = conf.fogEnable ? fogIntensity : 16'hffff;

    valueDelay #(.payloadT(logic [15:0]), .depth(fogAlign)) uIntensityDelay (
        .aclk  (aclk),
        .arstN (arstN),
        .in    (fogIntensitySel),
        .out   (intensityAligned)
    );

    // Primary colour waits for the texel
    valueDelay #(.payloadT(fragmentPkg::pixelT), .depth(`FRAG_LAT_SAMPLE)) uColorDelay (
        .aclk  (aclk),
        .arstN (arstN),
        .in    (inFrag.color),
        .out   (primaryAligned)
    );

    //////////////////////////////////////////////////////////////////////
    // Combine, then fog
    //////////////////////////////////////////////////////////////////////

    texEnv uTexEnv (
        .aclk     (aclk),
        .arstN    (arstN),
        .func     (conf.texEnvFunc),
        .texel    (texel),
        .primary  (primaryAligned),
        .envColor (conf.envColor),
        .color    (envOut)
    );

    fogBlend uFogBlend (
        .aclk      (aclk),
        .arstN     (arstN),
        .intensity (intensityAligned),
        .color     (envOut),
        .fogColor  (conf.fogColor),
        .blended   (outColor)
    );

    // Valid bit rides alongside the whole pipe
    valueDelay #(.payloadT(logic), .depth(`FRAG_LATENCY)) uValidDelay (
        .aclk  (aclk),
        .arstN (arstN),
        .in    (inValid),
        .out   (outValid)
    );

endmodule

/* design/fragmentPkg.sv */
package fragmentPkg;

    // RGBA colour, r in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] a;
    } pixelT;

    // Signed Q1.14 texture coordinate
    typedef logic signed [15:0] texCoordT;

    // One fragment from the rasterizer
    typedef struct packed {
        pixelT       color;
        logic [15:0] depth;
        texCoordT    s;
        texCoordT    t;
    } fragmentT;

    // Texture environment functions
    typedef enum logic [1:0] {
        Replace  = 2'd0,
        Modulate = 2'd1,
        Add      = 2'd2,
        Blend    = 2'd3
    } texEnvFuncE;

    // Quasi-static stage configuration
    typedef struct packed {
        texEnvFuncE texEnvFunc;
        logic       clampS;   // 1 clamps to edge, 0 wraps
        logic       clampT;
        pixelT      envColor;
        pixelT      fogColor;
        logic       fogEnable;
    } confT;

    // Fog table entry, also the fog stream beat
    typedef struct packed {
        logic [15:0]        base;
        logic signed [15:0] slope;
    } fogEntryT;

endpackage

/* design/fragment_defs.svh */
`ifndef FRAGMENT_DEFS_SVH
`define FRAGMENT_DEFS_SVH

// Texture geometry, log2 of the side length
`define FRAG_TEX_LOG2 4

// Fog table size
`define FRAG_FOG_ENTRIES 16

// Fraction bits of a Q1.14 texture coordinate
`define FRAG_FRAC_BITS 14

// Per-stage latencies in clock cycles
`define FRAG_LAT_SAMPLE 2
`define FRAG_LAT_FOGLUT 3
`define FRAG_LAT_TEXENV 2
`define FRAG_LAT_BLEND 2

// Fragment in to colour out
`define FRAG_LATENCY (`FRAG_LAT_SAMPLE + `FRAG_LAT_TEXENV + `FRAG_LAT_BLEND)

`endif

/* design/texEnv.sv */
`timescale 1ns/1ps

module texEnv
(
    input  logic                    aclk,
    input  logic                    arstN,
    input  fragmentPkg::texEnvFuncE func,
    input  fragmentPkg::pixelT      texel,
    input  fragmentPkg::pixelT      primary,
    input  fragmentPkg::pixelT      envColor,
    output fragmentPkg::pixelT      color
);

    // Channel views, index 3 is red and 0 is alpha
    logic [3:0][7:0] texCh;
    logic [3:0][7:0] priCh;
    logic [3:0][7:0] envCh;

    // Stage 1 registers
    fragmentPkg::texEnvFuncE funcQ;
    logic [3:0][7:0]  texQ;
    logic [3:0][15:0] modProd;
    logic [3:0][15:0] blendProd;
    logic [3:0][8:0]  addSum;

    logic [3:0][7:0] result;

    assign texCh = texel;
    assign priCh = primary;
    assign envCh = envColor;

    //////////////////////////////////////////////////////////////////////
    // Stage 1, products and sums
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            funcQ     <= fragmentPkg::Replace;
            texQ      <= '0;
            modProd   <= '0;
            blendProd <= '0;
            addSum    <= '0;
        end
        else
        begin
            funcQ <= func;
            texQ  <= texCh;
            for (int i = 0; i < 4; i++)
            begin
                modProd[i] <= texCh[i] * priCh[i];
                addSum[i]  <= texCh[i] + priCh[i];
            end
            // Weights sum to 255, fits 16 bits
            for (int i = 1; i < 4; i++)
                blendProd[i] <= priCh[i] * (8'd255 - texCh[i]) + envCh[i] * texCh[i];
            // Alpha under Blend is modulate
            blendProd[0] <= texCh[0] * priCh[0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2, select and saturate
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        logic [15:0] modRound;
        logic [15:0] blendRound;
        for (int i = 0; i < 4; i++)
        begin
            modRound   = modProd[i] + 16'd255;
            blendRound = blendProd[i] + 16'd255;
            case (funcQ)
                fragmentPkg::Replace:  result[i] = texQ[i];
                fragmentPkg::Modulate: result[i] = modRound[15:8];
                fragmentPkg::Add:      result[i] = addSum[i][8] ? 8'hff : addSum[i][7:0];
                fragmentPkg::Blend:    result[i] = blendRound[15:8];
                default:               result[i] = texQ[i];
            endcase
        end
    end

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
            color <= '0;
        else
            color <= result;
    end

endmodule

/* design/textureSampler.sv */
`timescale 1ns/1ps
`include "fragment_defs.svh"

module textureSampler
(
    input  logic                  aclk,
    input  logic                  arstN,
    input  fragmentPkg::texCoordT s,
    input  fragmentPkg::texCoordT t,
    input  logic                  clampS,
    input  logic                  clampT,
    input  logic                  texValid,
    output logic                  texReady,
    input  logic                  texLast,
    input  fragmentPkg::pixelT    texData,
    output fragmentPkg::pixelT    texel
);

    localparam int indexBits = `FRAG_TEX_LOG2;
    localparam int fracBits  = `FRAG_FRAC_BITS;
    localparam int texWords  = 1 << (2 * indexBits);

    fragmentPkg::pixelT texMem [texWords];
    logic [2*indexBits-1:0] wrIdx;
    logic [2*indexBits-1:0] rdAddr;

    // Clamp or wrap one coordinate, return its texel index
    function automatic logic [indexBits-1:0] texIndex(
        input fragmentPkg::texCoordT coord,
        input logic                  clampMode
    );
        logic [fracBits-1:0] frac;
        frac = coord[fracBits-1:0];
        if (clampMode)
        begin
            // Sign bit set means below zero
            if (coord[$bits(coord)-1])
                frac = '0;
            // Integer bit set means 1.0 or more
            else if (coord[fracBits])
                frac = '1;
        end
        return frac[fracBits-1 -: indexBits];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Load stream
    //////////////////////////////////////////////////////////////////////

    // Ready rises once reset is released
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
            texReady <= 1'b0;
        else
            texReady <= 1'b1;
    end

    // Row-major write index, last restarts at texel 0
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
            wrIdx <= '0;
        else if (texValid && texReady)
            wrIdx <= texLast ? '0 : wrIdx + 1'b1;
    end

    always_ff @(posedge aclk)
    begin
        if (texValid && texReady)
            texMem[wrIdx] <= texData;
    end

    //////////////////////////////////////////////////////////////////////
    // Lookup, address then read
    //////////////////////////////////////////////////////////////////////

    // Stage 1, t selects the row
    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
            rdAddr <= '0;
        else
            rdAddr <= {texIndex(t, clampT), texIndex(s, clampS)};
    end

    // Stage 2, nearest texel
    always_ff @(posedge aclk)
    begin
        texel <= texMem[rdAddr];
    end

endmodule

/* design/valueDelay.sv */
`timescale 1ns/1ps

module valueDelay
#(
    parameter type payloadT = logic,
    parameter int  depth    = 1
)
(
    input  logic    aclk,
    input  logic    arstN,
    input  payloadT in,
    output payloadT out
);

    // One register per cycle of delay
    payloadT stages [depth];

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < depth; i++)
                stages[i] <= '0;
        end
        else
        begin
            stages[0] <= in;
            // Shift toward the tail
            for (int i = 1; i < depth; i++)
                stages[i] <= stages[i - 1];
        end
    end

    assign out = stages[depth - 1];

endmodule

/* fragmentPipeline.f */
+incdir+design
design/fragmentPkg.sv
design/valueDelay.sv
design/textureSampler.sv
design/fogInterpolator.sv
design/texEnv.sv
design/fogBlend.sv
design/fragmentPipeline.sv
tests/fragmentPipeline_chk.sv
tests/fragmentPipelineTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fragmentPipelineTb \
    -f fragmentPipeline.f \
    -o simv

./obj_dir/simv | tee sim.log

if grep -q "Simulation passed" sim.log
then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* tests/fragmentPipelineTb.sv */
`timescale 1ns/1ps
`include "fragment_defs.svh"

module fragmentPipelineTb;

    localparam int halfPeriod  = 50;
    localparam int resetCycles = 5;
    localparam int driveDelay  = 1;

    logic                  aclk;
    logic                  arstN;
    fragmentPkg::confT     conf;
    logic                  inValid;
    fragmentPkg::fragmentT inFrag;
    logic                  texValid;
    logic                  texReady;
    logic                  texLast;
    fragmentPkg::pixelT    texData;
    logic                  fogValid;
    logic                  fogReady;
    logic                  fogLast;
    fragmentPkg::fogEntryT fogData;
    logic                  outValid;
    fragmentPkg::pixelT    outColor;

    // Colours still owed by the DUT, oldest first
    fragmentPkg::pixelT expected [$];
    int seed = 5071;
    int recordCount = 0;
    int waitCycles = 0;
    int fd;

    fragmentPipeline u_dut (
        .aclk     (aclk),
        .arstN    (arstN),
        .conf     (conf),
        .inValid  (inValid),
        .inFrag   (inFrag),
        .texValid (texValid),
        .texReady (texReady),
        .texLast  (texLast),
        .texData  (texData),
        .fogValid (fogValid),
        .fogReady (fogReady),
        .fogLast  (fogLast),
        .fogData  (fogData),
        .outValid (outValid),
        .outColor (outColor)
    );

    always #(halfPeriod) aclk = ~aclk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    // Inputs change just after the rising edge
    task automatic nextCycle();
        @(posedge aclk);
        #(driveDelay);
    endtask

    // One cycle spent waiting, bounded by the test length
    task automatic waitCycle();
        nextCycle();
        waitCycles++;
        if (waitCycles > (recordCount + `FRAG_LATENCY) * 4)
            abortRun("Timeout: an expected output never arrived or a stream stayed not ready");
    endtask

    task automatic drainOutputs();
        while (expected.size() != 0)
            waitCycle();
    endtask

    // Texel contents follow the full row-major address
    function automatic fragmentPkg::pixelT texelPattern(input int index);
        logic [7:0] idx;
        fragmentPkg::pixelT px;
        idx  = index[7:0];
        px.r = idx;
        px.g = 8'hff - idx;
        px.b = {idx[3:0], idx[7:4]};
        px.a = idx + 8'h40;
        return px;
    endfunction

    // Whole texture burst, last on the final beat
    task automatic loadTexture(input int count);
        for (int i = 0; i < count; i++)
        begin
            texValid = 1'b1;
            texData  = texelPattern(i);
            texLast  = (i == count - 1);
            while (!texReady)
                waitCycle();
            nextCycle();
        end
        texValid = 1'b0;
        texLast  = 1'b0;
    endtask

    task automatic sendFogBeat(input logic [15:0] base, input logic [15:0] slope,
                               input logic last);
        fogValid      = 1'b1;
        fogData.base  = base;
        fogData.slope = slope;
        fogLast       = last;
        while (!fogReady)
            waitCycle();
        nextCycle();
        fogValid = 1'b0;
        fogLast  = 1'b0;
    endtask

    task automatic driveFragment(input logic [31:0] color, input logic [15:0] depth,
                                 input logic [15:0] s, input logic [15:0] t,
                                 input logic [31:0] want);
        inValid      = 1'b1;
        inFrag.color = color;
        inFrag.depth = depth;
        inFrag.s     = s;
        inFrag.t     = t;
        expected.push_back(want);
        nextCycle();
        inValid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output checker, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge aclk)
    begin : outputMonitor
        fragmentPkg::pixelT want;
        if (arstN && outValid)
        begin
            assert (expected.size() != 0)
            else abortRun("An output appeared with no fragment outstanding");
            want = expected.pop_front();
            assert (outColor == want)
            else abortRun($sformatf("CHECK FAILED outColor got %h expected %h", outColor, want));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus from the record file
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        byte               kind;
        logic [31:0]       a, b, c, d, e, f;
        logic [8*256-1:0]  lineBuf;
        int                code;
        int                gap;

        aclk     = 1'b0;
        arstN    = 1'b0;
        conf     = '0;
        inValid  = 1'b0;
        inFrag   = '0;
        texValid = 1'b0;
        texLast  = 1'b0;
        texData  = '0;
        fogValid = 1'b0;
        fogLast  = 1'b0;
        fogData  = '0;

        repeat (resetCycles) @(posedge aclk);
        #(driveDelay) arstN = 1'b1;
        nextCycle();

        // Both streams open and no stray output
        assert (texReady && fogReady)
        else abortRun("Stream ready outputs stayed low after reset");
        assert (!outValid)
        else abortRun($sformatf("CHECK FAILED outValid got %h expected 0", outValid));

        fd = $fopen("tests/fragment_stimulus.txt", "r");
        if (fd == 0)
            abortRun("Could not open tests/fragment_stimulus.txt");

        code = $fscanf(fd, " %c", kind);
        while (code == 1)
        begin
            if (kind == "#")
                code = $fgets(lineBuf, fd);
            else
            begin
                recordCount++;
                case (kind)
                    "C":
                    begin
                        if ($fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f) != 6)
                            abortRun("Malformed configuration record");
                        // Conf is quasi-static, so nothing may be in flight
                        drainOutputs();
                        conf.texEnvFunc = fragmentPkg::texEnvFuncE'(a[1:0]);
                        conf.clampS     = b[0];
                        conf.clampT     = c[0];
                        conf.envColor   = d;
                        conf.fogColor   = e;
                        conf.fogEnable  = f[0];
                    end
                    "X":
                    begin
                        if ($fscanf(fd, "%h", a) != 1)
                            abortRun("Malformed texel record");
                        drainOutputs();
                        loadTexture(int'(a));
                    end
                    "L":
                    begin
                        if ($fscanf(fd, "%h %h %h", a, b, c) != 3)
                            abortRun("Malformed fog record");
                        drainOutputs();
                        sendFogBeat(a[15:0], b[15:0], c[0]);
                    end
                    "F":
                    begin
                        if ($fscanf(fd, "%h %h %h %h %h", a, b, c, d, e) != 5)
                            abortRun("Malformed fragment record");
                        driveFragment(a, b[15:0], c[15:0], d[15:0], e);
                    end
                    "G":
                    begin
                        if ($fscanf(fd, "%h", a) != 1)
                            abortRun("Malformed gap record");
                        // Random idle run of 0 up to the given maximum
                        gap = {$random(seed)} % (a + 1);
                        repeat (gap) nextCycle();
                    end
                    default:
                        abortRun("Unknown record kind in the stimulus file");
                endcase
            end
            code = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);

        drainOutputs();
        // Extra outputs here would be duplicates
        repeat (`FRAG_LATENCY) nextCycle();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* tests/fragmentPipeline_chk.sv */
`timescale 1ns/1ps
`include "fragment_defs.svh"

module fragmentPipelineChk
(
    input logic               aclk,
    input logic               arstN,
    input logic               inValid,
    input logic               outValid,
    input logic               texReady,
    input logic               fogReady,
    input fragmentPkg::pixelT outColor
);

    // inValid history, newest in bit 0
    logic [`FRAG_LATENCY-1:0] validHist;

    always_ff @(posedge aclk or negedge arstN)
    begin
        if (!arstN)
            validHist <= '0;
        else
            validHist <= {validHist[`FRAG_LATENCY-2:0], inValid};
    end

    // Every fragment leaves exactly six cycles later
    validLatency: assert property (@(posedge aclk) disable iff (!arstN)
        outValid == validHist[`FRAG_LATENCY-1])
        else $error("outValid does not follow inValid by the pipeline latency");

    // Streams closed while in reset
    readyInReset: assert property (@(posedge aclk)
        !arstN |-> (!texReady && !fogReady))
        else $error("stream ready high during reset");

    colorKnown: assert property (@(posedge aclk) disable iff (!arstN)
        outValid |-> !$isunknown(outColor))
        else $error("outColor unknown while outValid is high");

endmodule

bind fragmentPipeline fragmentPipelineChk uChk (
    .aclk     (aclk),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (outValid),
    .texReady (texReady),
    .fogReady (fogReady),
    .outColor (outColor)
);

/* tests/fragment_stimulus.txt */
# C func clampS clampT envColor fogColor fogEnable | X texelCount | G maxIdleCycles
# L fogBase fogSlope last | F color depth s t expectedColor (all values hex)
X 100
L FFFF 0000 0
L F000 7FFF 0
L E000 F000 0
L D000 F000 0
L C000 F000 0
L B000 F000 0
L A000 F000 0
L 9000 F000 0
L 8000 F000 0
L 7000 F000 0
L 6000 F000 0
L 5000 F000 0
L 4000 F000 0
L 3000 F000 0
L 2000 F000 0
L 0800 8000 1
C 0 1 1 00000000 00000000 0
F 11223344 0000 C000 FFFF 00FE0040
G 3
F 11223344 0000 4000 7FFF FE00FE3F
F 11223344 0000 2800 0C00 39C4A27A
C 0 0 0 00000000 00000000 0
F 11223344 0000 E400 FFFF F8059E39
G 5
F 11223344 0000 4000 7C00 EF0E0E30
C 1 0 0 00000000 00000000 0
F 80FF10C8 0000 0400 0800 10DD014C
C 2 0 0 00000000 00000000 0
F 8040F0C0 0000 0400 0800 A0FEFEFF
C 3 0 0 20406080 00000000 0
F 80FF10C8 0000 0400 0800 7358154C
C 0 1 1 00000000 FF800011 1
F 11223344 1800 2800 0C00 39C4A27A
F 11223344 F400 2800 0C00 FE7F007A
G 4
F 11223344 8000 2800 0C00 9CA2517A
F 11223344 4C00 2800 0C00 74B0727A
L 4000 0000 0
L 1234 0000 1
F 11223344 0ABC 2800 0C00 CD91287A
F 11223344 1FFF 2800 0C00 F0840B7A
G 2
F 11223344 2000 2800 0C00 52BC8E7A
